/* rtl/cpuPkg.sv */
package cpuPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    typedef logic [DataWidth-1:0]    wordT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    localparam wordT ResetPc  = 32'h0000_0000;
    localparam wordT NopInstr = 32'h0000_0000;   // sll $0, $0, 0

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        J       = 6'h02,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        ADDIU   = 6'h09,
        ORI     = 6'h0d,
        LUI     = 6'h0f,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcodeE;

    // funct field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        SLT  = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI   // passes the pre-shifted immediate
    } aluOpE;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSelE;

endpackage

/* rtl/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit
    import cpuPkg::*;
(
    input  logic clk,
    input  logic rstN_i,
    input  logic freeze_i,
    input  logic stall_i,        // load-use hold
    input  logic flush_i,
    input  logic redirect_i,
    input  wordT redirectPc_i,
    input  wordT instr_i,
    output wordT pc_o,
    output wordT instrD_o,
    output wordT pcD_o
);
    wordT nextPc;

    assign nextPc = redirect_i ? redirectPc_i : pc_o + 32'd4;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pc_o     <= ResetPc;
            instrD_o <= NopInstr;
        end else if (!freeze_i && !stall_i) begin
            pc_o     <= nextPc;
            // word behind the delay slot is dropped
            instrD_o <= flush_i ? NopInstr : instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i && !stall_i) begin
            pcD_o <= pc_o;
        end
    end

endmodule

/* rtl/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit
    import cpuPkg::*;
(
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        freeze_i,
    input  logic        stall_i,
    input  logic        bubble_i,
    input  wordT        instrD_i,
    input  wordT        pcD_i,
    input  wordT        rsData_i,
    input  wordT        rtData_i,
    output regAddrT     rsD_o,
    output regAddrT     rtD_o,
    output logic        useRsD_o,
    output logic        useRtD_o,
    output aluOpE       aluOpE_o,
    output wordT        opA_o,
    output wordT        opB_o,
    output wordT        imm_o,
    output wordT        pcE_o,
    output logic        useImmE_o,
    output logic [4:0]  shamtE_o,
    output regAddrT     rsE_o,
    output regAddrT     rtE_o,
    output regAddrT     destE_o,
    output logic        regWriteE_o,
    output logic        loadE_o,
    output logic        storeE_o,
    output logic        branchE_o,
    output logic        branchNeE_o,
    output logic        jumpE_o,
    output logic [25:0] jumpIdxE_o
);
    opcodeE  op;
    functE   fn;
    aluOpE   aluOp;
    wordT    imm;
    regAddrT dest;
    logic    useImm, destRd, regWrite, load, store, branch, branchNe, jump;

    assign op    = opcodeE'(instrD_i[31:26]);
    assign fn    = functE'(instrD_i[5:0]);
    assign rsD_o = instrD_i[25:21];
    assign rtD_o = instrD_i[20:16];
    assign dest  = destRd ? instrD_i[15:11] : instrD_i[20:16];

    always_comb begin
        aluOp    = ALU_ADD;
        useRsD_o = 1'b0;
        useRtD_o = 1'b0;
        useImm   = 1'b0;
        destRd   = 1'b0;
        regWrite = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        jump     = 1'b0;
        case (op)
            SPECIAL: begin
                useRsD_o = 1'b1;
                useRtD_o = 1'b1;
                destRd   = 1'b1;
                regWrite = 1'b1;
                case (fn)
                    ADDU: aluOp = ALU_ADD;
                    SUBU: aluOp = ALU_SUB;
                    AND:  aluOp = ALU_AND;
                    OR:   aluOp = ALU_OR;
                    XOR:  aluOp = ALU_XOR;
                    SLT:  aluOp = ALU_SLT;
                    SLL: begin
                        aluOp    = ALU_SLL;
                        useRsD_o = 1'b0;   // shifts rt only
                    end
                    default: begin
                        // unknown funct acts as nop
                        useRsD_o = 1'b0;
                        useRtD_o = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            ADDIU, ORI, LW: begin
                aluOp    = (op == ORI) ? ALU_OR : ALU_ADD;
                useRsD_o = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
                load     = (op == LW);
            end
            LUI: begin
                aluOp    = ALU_LUI;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            SW: begin
                useRsD_o = 1'b1;
                useRtD_o = 1'b1;   // store data
                useImm   = 1'b1;
                store    = 1'b1;
            end
            BEQ, BNE: begin
                aluOp    = ALU_SUB;   // compare by subtraction
                useRsD_o = 1'b1;
                useRtD_o = 1'b1;
                branch   = 1'b1;
                branchNe = (op == BNE);
            end
            J:       jump = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            ORI:     imm = {16'h0000, instrD_i[15:0]};
            LUI:     imm = {instrD_i[15:0], 16'h0000};
            default: imm = {{16{instrD_i[15]}}, instrD_i[15:0]};
        endcase
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteE_o <= 1'b0;
            loadE_o     <= 1'b0;
            storeE_o    <= 1'b0;
            branchE_o   <= 1'b0;
            branchNeE_o <= 1'b0;
            jumpE_o     <= 1'b0;
        end else if (!freeze_i) begin
            regWriteE_o <= !bubble_i && regWrite && dest != '0;   // r0 writes dropped here
            loadE_o     <= !bubble_i && load;
            storeE_o    <= !bubble_i && store;
            branchE_o   <= !bubble_i && branch;
            branchNeE_o <= !bubble_i && branchNe;
            jumpE_o     <= !bubble_i && jump;
        end
    end

    // payload stays put behind a bubble
    always_ff @(posedge clk) begin
        if (!freeze_i && !stall_i) begin
            aluOpE_o   <= aluOp;
            opA_o      <= rsData_i;
            opB_o      <= rtData_i;
            imm_o      <= imm;
            pcE_o      <= pcD_i;
            useImmE_o  <= useImm;
            shamtE_o   <= instrD_i[10:6];
            rsE_o      <= rsD_o;
            rtE_o      <= rtD_o;
            destE_o    <= dest;
            jumpIdxE_o <= instrD_i[25:0];
        end
    end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    rstN_i,
    input  regAddrT raddrA_i,
    input  regAddrT raddrB_i,
    input  regAddrT waddr_i,
    input  logic    we_i,
    input  wordT    wdata_i,
    output wordT    rdataA_o,
    output wordT    rdataB_o
);
    wordT regs [1:31];   // no storage for r0

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regs <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic wordT readPort(regAddrT addr);
        if (addr == '0) return '0;
        if (we_i && addr == waddr_i) return wdata_i;   // write in flight wins
        return regs[addr];
    endfunction

    always_comb begin
        rdataA_o = readPort(raddrA_i);
        rdataB_o = readPort(raddrB_i);
    end

endmodule

/* rtl/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit
    import cpuPkg::*;
(
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        freeze_i,
    input  aluOpE       aluOpE_i,
    input  wordT        opA_i,
    input  wordT        opB_i,
    input  wordT        imm_i,
    input  wordT        pcE_i,
    input  logic        useImmE_i,
    input  logic [4:0]  shamtE_i,
    input  regAddrT     destE_i,
    input  logic        regWriteE_i,
    input  logic        loadE_i,
    input  logic        storeE_i,
    input  logic        branchE_i,
    input  logic        branchNeE_i,
    input  logic        jumpE_i,
    input  logic [25:0] jumpIdxE_i,
    input  fwdSelE      fwdA_i,
    input  fwdSelE      fwdB_i,
    input  wordT        resultM_i,
    input  wordT        resultW_i,
    output logic        takenE_o,
    output wordT        targetE_o,
    output wordT        aluOutM_o,
    output wordT        storeDataM_o,
    output regAddrT     destM_o,
    output logic        regWriteM_o,
    output logic        loadM_o,
    output logic        storeM_o,
    output wordT        pcM_o
);
    wordT srcA, srcB, aluB, aluRes, pcPlus4;

    function automatic wordT pickOperand(fwdSelE sel, wordT regVal, wordT memVal,
                                         wordT wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA_i, opA_i, resultM_i, resultW_i);
    assign srcB = pickOperand(fwdB_i, opB_i, resultM_i, resultW_i);
    assign aluB = useImmE_i ? imm_i : srcB;

    always_comb begin
        case (aluOpE_i)
            ALU_SUB: aluRes = srcA - aluB;
            ALU_AND: aluRes = srcA & aluB;
            ALU_OR:  aluRes = srcA | aluB;
            ALU_XOR: aluRes = srcA ^ aluB;
            ALU_SLT: aluRes = {31'b0, $signed(srcA) < $signed(aluB)};
            ALU_SLL: aluRes = aluB << shamtE_i;
            ALU_LUI: aluRes = aluB;
            default: aluRes = srcA + aluB;
        endcase
    end

    // beq takes on a zero difference, bne on nonzero
    assign pcPlus4   = pcE_i + 32'd4;
    assign takenE_o  = jumpE_i | (branchE_i & ((aluRes == '0) ^ branchNeE_i));
    assign targetE_o = jumpE_i ? {pcPlus4[31:28], jumpIdxE_i, 2'b00}
                               : pcPlus4 + {imm_i[29:0], 2'b00};

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteM_o <= 1'b0;
            loadM_o     <= 1'b0;
            storeM_o    <= 1'b0;
        end else if (!freeze_i) begin
            regWriteM_o <= regWriteE_i;
            loadM_o     <= loadE_i;
            storeM_o    <= storeE_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            aluOutM_o    <= aluRes;
            storeDataM_o <= srcB;   // forwarded rt
            destM_o      <= destE_i;
            pcM_o        <= pcE_i;
        end
    end

endmodule

/* rtl/memoryUnit.sv */
`timescale 1ns/1ps

module memoryUnit
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    freeze_i,
    input  wordT    aluOutM_i,
    input  wordT    storeDataM_i,
    input  regAddrT destM_i,
    input  logic    regWriteM_i,
    input  logic    loadM_i,
    input  logic    storeM_i,
    input  wordT    pcM_i,
    input  wordT    dataRdata_i,
    output logic    dataRe_o,
    output logic    dataWe_o,
    output wordT    dataAddr_o,
    output wordT    dataWdata_o,
    output wordT    resultM_o,
    output regAddrT destW_o,
    output logic    regWriteW_o,
    output wordT    resultW_o,
    output wordT    pcW_o
);
    logic regWriteW;

    assign dataRe_o    = loadM_i;
    assign dataWe_o    = storeM_i;
    assign dataAddr_o  = aluOutM_i;
    assign dataWdata_o = storeDataM_i;
    assign resultM_o   = loadM_i ? dataRdata_i : aluOutM_i;   // also the forward source

    // no commit while the pipeline is frozen
    assign regWriteW_o = regWriteW & ~freeze_i;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteW <= 1'b0;
        end else if (!freeze_i) begin
            regWriteW <= regWriteM_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            destW_o   <= destM_i;
            resultW_o <= resultM_o;
            pcW_o     <= pcM_i;
        end
    end

endmodule

/* rtl/hazardCtrl.sv */
`timescale 1ns/1ps

module hazardCtrl
    import cpuPkg::*;
(
    input  logic    iStall_i,
    input  logic    dStall_i,
    input  regAddrT rsD_i,
    input  regAddrT rtD_i,
    input  logic    useRsD_i,
    input  logic    useRtD_i,
    input  regAddrT destE_i,
    input  logic    loadE_i,
    input  regAddrT destM_i,
    input  logic    regWriteM_i,
    input  regAddrT destW_i,
    input  logic    regWriteW_i,
    input  regAddrT rsE_i,
    input  regAddrT rtE_i,
    input  logic    takenE_i,
    input  wordT    targetE_i,
    output logic    freeze_o,
    output logic    stallFront_o,
    output logic    bubbleE_o,
    output logic    flushD_o,
    output logic    redirect_o,
    output wordT    redirectPc_o,
    output fwdSelE  fwdA_o,
    output fwdSelE  fwdB_o
);
    logic loadUse;

    // youngest producer first
    function automatic fwdSelE fwdFor(regAddrT src, regAddrT dM, logic wM, regAddrT dW,
                                      logic wW);
        if (wM && dM != '0 && dM == src) return FWD_MEM;
        if (wW && dW != '0 && dW == src) return FWD_WB;
        return FWD_REG;
    endfunction

    assign freeze_o = iStall_i | dStall_i;

    assign loadUse = loadE_i && destE_i != '0
                     && ((useRsD_i && rsD_i == destE_i) || (useRtD_i && rtD_i == destE_i));
    assign stallFront_o = loadUse;
    assign bubbleE_o    = loadUse;

    // delay slot sits in decode, so only the fetch after it goes
    assign redirect_o   = takenE_i;
    assign redirectPc_o = targetE_i;
    assign flushD_o     = takenE_i & ~loadUse;

    assign fwdA_o = fwdFor(rsE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);
    assign fwdB_o = fwdFor(rtE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);

endmodule

/* rtl/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    rstN_i,
    output wordT    instrAddr_o,
    input  wordT    instr_i,
    input  logic    iStall_i,
    output logic    dataRe_o,
    output logic    dataWe_o,
    output wordT    dataAddr_o,
    output wordT    dataWdata_o,
    input  wordT    dataRdata_i,
    input  logic    dStall_i,
    output logic    wbValid_o,
    output wordT    wbPc_o,
    output regAddrT wbReg_o,
    output wordT    wbData_o
);
    logic        freeze, stallFront, bubbleE, flushD, redirect, takenE;
    wordT        redirectPc, targetE;
    fwdSelE      fwdA, fwdB;
    wordT        instrD, pcD, rsData, rtData;
    regAddrT     rsD, rtD, rsE, rtE, destE, destM, destW;
    logic        useRsD, useRtD, useImmE;
    aluOpE       aluOp;
    wordT        opA, opB, immE, pcE;
    logic [4:0]  shamtE;
    logic [25:0] jumpIdxE;
    logic        regWriteE, loadE, storeE, branchE, branchNeE, jumpE;
    wordT        aluOutM, storeDataM, pcM, resultM, resultW, pcW;
    logic        regWriteM, loadM, storeM, regWriteW;

    // trace follows the writeback register
    assign wbValid_o = regWriteW;
    assign wbPc_o    = pcW;
    assign wbReg_o   = destW;
    assign wbData_o  = resultW;

    fetchUnit i_fetch (
        .clk(clk), .rstN_i(rstN_i), .freeze_i(freeze), .stall_i(stallFront),
        .flush_i(flushD), .redirect_i(redirect), .redirectPc_i(redirectPc),
        .instr_i(instr_i), .pc_o(instrAddr_o), .instrD_o(instrD), .pcD_o(pcD)
    );

    decodeUnit i_decode (
        .clk(clk), .rstN_i(rstN_i), .freeze_i(freeze), .stall_i(stallFront),
        .bubble_i(bubbleE), .instrD_i(instrD), .pcD_i(pcD),
        .rsData_i(rsData), .rtData_i(rtData),
        .rsD_o(rsD), .rtD_o(rtD), .useRsD_o(useRsD), .useRtD_o(useRtD),
        .aluOpE_o(aluOp), .opA_o(opA), .opB_o(opB), .imm_o(immE), .pcE_o(pcE),
        .useImmE_o(useImmE), .shamtE_o(shamtE), .rsE_o(rsE), .rtE_o(rtE),
        .destE_o(destE), .regWriteE_o(regWriteE), .loadE_o(loadE), .storeE_o(storeE),
        .branchE_o(branchE), .branchNeE_o(branchNeE), .jumpE_o(jumpE),
        .jumpIdxE_o(jumpIdxE)
    );

    regFile i_regFile (
        .clk(clk), .rstN_i(rstN_i), .raddrA_i(rsD), .raddrB_i(rtD),
        .waddr_i(destW), .we_i(regWriteW), .wdata_i(resultW),
        .rdataA_o(rsData), .rdataB_o(rtData)
    );

    executeUnit i_execute (
        .clk(clk), .rstN_i(rstN_i), .freeze_i(freeze),
        .aluOpE_i(aluOp), .opA_i(opA), .opB_i(opB), .imm_i(immE), .pcE_i(pcE),
        .useImmE_i(useImmE), .shamtE_i(shamtE), .destE_i(destE),
        .regWriteE_i(regWriteE), .loadE_i(loadE), .storeE_i(storeE),
        .branchE_i(branchE), .branchNeE_i(branchNeE), .jumpE_i(jumpE),
        .jumpIdxE_i(jumpIdxE), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .resultM_i(resultM), .resultW_i(resultW),
        .takenE_o(takenE), .targetE_o(targetE), .aluOutM_o(aluOutM),
        .storeDataM_o(storeDataM), .destM_o(destM), .regWriteM_o(regWriteM),
        .loadM_o(loadM), .storeM_o(storeM), .pcM_o(pcM)
    );

    memoryUnit i_memory (
        .clk(clk), .rstN_i(rstN_i), .freeze_i(freeze),
        .aluOutM_i(aluOutM), .storeDataM_i(storeDataM), .destM_i(destM),
        .regWriteM_i(regWriteM), .loadM_i(loadM), .storeM_i(storeM), .pcM_i(pcM),
        .dataRdata_i(dataRdata_i), .dataRe_o(dataRe_o), .dataWe_o(dataWe_o),
        .dataAddr_o(dataAddr_o), .dataWdata_o(dataWdata_o), .resultM_o(resultM),
        .destW_o(destW), .regWriteW_o(regWriteW), .resultW_o(resultW), .pcW_o(pcW)
    );

    hazardCtrl i_hazard (
        .iStall_i(iStall_i), .dStall_i(dStall_i),
        .rsD_i(rsD), .rtD_i(rtD), .useRsD_i(useRsD), .useRtD_i(useRtD),
        .destE_i(destE), .loadE_i(loadE), .destM_i(destM), .regWriteM_i(regWriteM),
        .destW_i(destW), .regWriteW_i(regWriteW), .rsE_i(rsE), .rtE_i(rtE),
        .takenE_i(takenE), .targetE_i(targetE),
        .freeze_o(freeze), .stallFront_o(stallFront), .bubbleE_o(bubbleE),
        .flushD_o(flushD), .redirect_o(redirect), .redirectPc_o(redirectPc),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

/* tests/cpuCoreTb.sv */
`timescale 1ns/1ps

module cpuCoreTb
    import cpuPkg::*;
();
    localparam int ResetCycles = 5;
    localparam int TailCycles  = 8;   // watch for stray commits after the last one
    // alu runs 14 words once, forward 9, mem 9 and branch 12 run twice
    localparam int TotalWords  = 14 + 2 * (9 + 9 + 12);
    localparam int CycleLimit  = TotalWords * 8 + ResetCycles * 7;

    logic    clk         = 1'b0;
    logic    rstN_i      = 1'b0;
    logic    iStall_i    = 1'b0;
    logic    dStall_i    = 1'b0;
    wordT    instr_i;
    wordT    dataRdata_i;
    wordT    instrAddr_o, dataAddr_o, dataWdata_o, wbPc_o, wbData_o;
    logic    dataRe_o, dataWe_o, wbValid_o;
    regAddrT wbReg_o;

    wordT    imem [0:255];
    wordT    dmem [0:255];
    int      progLen;
    logic    fillData   = 1'b0;
    logic    collecting = 1'b0;
    logic    stallOn    = 1'b0;
    integer  seed       = 32'hd373;
    int      cycles     = 0;

    wordT    expPc[$];
    regAddrT expReg[$];
    wordT    expData[$];
    wordT    gotPc[$];
    regAddrT gotReg[$];
    wordT    gotData[$];

    cpuCore i_dut (
        .clk(clk), .rstN_i(rstN_i), .instrAddr_o(instrAddr_o), .instr_i(instr_i),
        .iStall_i(iStall_i), .dataRe_o(dataRe_o), .dataWe_o(dataWe_o),
        .dataAddr_o(dataAddr_o), .dataWdata_o(dataWdata_o), .dataRdata_i(dataRdata_i),
        .dStall_i(dStall_i), .wbValid_o(wbValid_o), .wbPc_o(wbPc_o), .wbReg_o(wbReg_o),
        .wbData_o(wbData_o)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // word-addressed memories, answered combinationally
    assign instr_i     = imem[instrAddr_o[9:2]];
    assign dataRdata_i = dataRe_o ? dmem[dataAddr_o[9:2]] : 'x;   // data only for a load

    function automatic wordT fillWord(int idx);
        return {8'hd0, 8'(idx), 8'(~idx), 8'(idx * 3)};
    endfunction

    always @(posedge clk) begin
        if (fillData) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (rstN_i && dataWe_o && !dStall_i) begin
            dmem[dataAddr_o[9:2]] <= dataWdata_o;
        end
    end

    always @(posedge clk) begin
        if (stallOn) begin
            iStall_i <= ($random(seed) & 7) == 0;
            dStall_i <= ($random(seed) & 7) == 0;
        end else begin
            iStall_i <= 1'b0;
            dStall_i <= 1'b0;
        end
    end

    task automatic failRun(string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // trace sampled mid-cycle where it is stable
    always @(negedge clk) begin
        if (collecting && wbValid_o) begin
            if (wbReg_o == '0) failRun("commit to register 0 seen on the trace");
            if (iStall_i || dStall_i) failRun("commit seen during a stalled cycle");
            gotPc.push_back(wbPc_o);
            gotReg.push_back(wbReg_o);
            gotData.push_back(wbData_o);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CycleLimit) failRun("timeout, the tests ran past the cycle limit");
    end

    task automatic checkWord(string testName, string what, wordT exp, wordT act);
        if (exp !== act) begin
            $display("** Error: %s: %s expected %h, actual %h", testName, what, exp, act);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic checkReg(string testName, regAddrT exp, regAddrT act);
        if (exp !== act) begin
            $display("** Error: %s: dest reg expected %0d, actual %0d", testName, exp, act);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic wordT rType(functE fn, regAddrT rs, regAddrT rt, regAddrT rd,
                                   logic [4:0] sh);
        return {SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iType(opcodeE op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jType(logic [25:0] idx);
        return {J, idx};
    endfunction

    task automatic newProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = NopInstr;
        end
        progLen = 0;
        expPc.delete();
        expReg.delete();
        expData.delete();
    endtask

    task automatic emit(wordT w);
        imem[progLen] = w;
        progLen++;
    endtask

    task automatic expectWrite(wordT pc, regAddrT r, wordT d);
        expPc.push_back(pc);
        expReg.push_back(r);
        expData.push_back(d);
    endtask

    // reset, run until every expected commit is seen, then compare in order
    task automatic runProgram(string testName, bit withStalls);
        gotPc.delete();
        gotReg.delete();
        gotData.delete();
        @(posedge clk);
        rstN_i   <= 1'b0;
        stallOn  <= withStalls;
        fillData <= 1'b1;
        @(posedge clk);
        fillData <= 1'b0;
        repeat (ResetCycles - 1) @(posedge clk);
        rstN_i     <= 1'b1;
        collecting <= 1'b1;
        while (gotReg.size() < expReg.size()) @(posedge clk);
        repeat (TailCycles) @(posedge clk);
        collecting <= 1'b0;
        if (gotReg.size() != expReg.size()) begin
            failRun($sformatf("%s: %0d commits seen, %0d expected", testName,
                              gotReg.size(), expReg.size()));
        end
        foreach (expReg[i]) begin
            checkWord(testName, $sformatf("pc of commit %0d", i), expPc[i], gotPc[i]);
            checkReg(testName, expReg[i], gotReg[i]);
            checkWord(testName, $sformatf("data of commit %0d", i), expData[i], gotData[i]);
        end
    endtask

    task automatic aluTest();
        newProgram();
        emit(iType(ADDIU, 0, 1, 16'd5));
        emit(iType(ADDIU, 0, 2, 16'hfffd));
        emit(iType(LUI, 0, 3, 16'h1234));
        emit(iType(ORI, 3, 3, 16'h8765));   // zero-extended
        emit(rType(ADDU, 1, 2, 4, 0));
        emit(rType(SUBU, 1, 2, 5, 0));
        emit(rType(AND, 3, 1, 6, 0));
        emit(rType(OR, 1, 4, 7, 0));
        emit(rType(XOR, 3, 2, 8, 0));
        emit(rType(SLT, 2, 1, 9, 0));
        emit(rType(SLT, 1, 2, 10, 0));
        emit(rType(SLL, 0, 1, 11, 4));
        emit(iType(ADDIU, 1, 0, 16'd7));    // r0 write, never on the trace
        emit(iType(ORI, 0, 12, 16'hffff));
        expectWrite(32'h00, 1, 32'h0000_0005);
        expectWrite(32'h04, 2, 32'hffff_fffd);
        expectWrite(32'h08, 3, 32'h1234_0000);
        expectWrite(32'h0c, 3, 32'h1234_8765);
        expectWrite(32'h10, 4, 32'h0000_0002);
        expectWrite(32'h14, 5, 32'h0000_0008);
        expectWrite(32'h18, 6, 32'h0000_0005);
        expectWrite(32'h1c, 7, 32'h0000_0007);
        expectWrite(32'h20, 8, 32'hedcb_7898);
        expectWrite(32'h24, 9, 32'h0000_0001);
        expectWrite(32'h28, 10, 32'h0000_0000);
        expectWrite(32'h2c, 11, 32'h0000_0050);
        expectWrite(32'h34, 12, 32'h0000_ffff);
        runProgram("aluImm", 1'b0);
    endtask

    task automatic forwardTest(bit withStalls);
        newProgram();
        emit(iType(ADDIU, 0, 1, 16'd10));
        emit(rType(ADDU, 1, 1, 2, 0));      // distance 1
        emit(rType(SUBU, 2, 1, 3, 0));      // distances 1 and 2
        emit(rType(ADDU, 1, 3, 4, 0));      // distance 3 through the register file
        emit(rType(XOR, 2, 4, 5, 0));
        emit(iType(ADDIU, 5, 5, 16'd7));
        emit(rType(SLL, 0, 5, 6, 2));
        emit(rType(ADDU, 6, 5, 7, 0));
        emit(rType(SUBU, 7, 4, 8, 0));
        expectWrite(32'h00, 1, 32'd10);
        expectWrite(32'h04, 2, 32'd20);
        expectWrite(32'h08, 3, 32'd10);
        expectWrite(32'h0c, 4, 32'd20);
        expectWrite(32'h10, 5, 32'd0);
        expectWrite(32'h14, 5, 32'd7);
        expectWrite(32'h18, 6, 32'd28);
        expectWrite(32'h1c, 7, 32'd35);
        expectWrite(32'h20, 8, 32'd15);
        runProgram(withStalls ? "forwardStall" : "forward", withStalls);
    endtask

    task automatic memTest(bit withStalls);
        string name;
        name = withStalls ? "loadStoreStall" : "loadStore";
        newProgram();
        emit(iType(ADDIU, 0, 1, 16'h0020));
        emit(iType(ADDIU, 0, 2, 16'h1234));
        emit(iType(SW, 1, 2, 16'd0));
        emit(iType(LW, 1, 3, 16'd0));       // reads the word just stored
        emit(iType(ADDIU, 3, 4, 16'd1));    // load-use
        emit(iType(SW, 1, 4, 16'd4));
        emit(iType(LW, 1, 5, 16'd4));
        emit(rType(ADDU, 5, 3, 6, 0));
        emit(iType(SW, 1, 6, 16'd8));
        expectWrite(32'h00, 1, 32'h0000_0020);
        expectWrite(32'h04, 2, 32'h0000_1234);
        expectWrite(32'h0c, 3, 32'h0000_1234);
        expectWrite(32'h10, 4, 32'h0000_1235);
        expectWrite(32'h18, 5, 32'h0000_1235);
        expectWrite(32'h1c, 6, 32'h0000_2469);
        runProgram(name, withStalls);
        checkWord(name, "dmem word 8", 32'h0000_1234, dmem[8]);
        checkWord(name, "dmem word 9", 32'h0000_1235, dmem[9]);
        checkWord(name, "dmem word 10", 32'h0000_2469, dmem[10]);
        checkWord(name, "dmem word 11", fillWord(11), dmem[11]);
    endtask

    task automatic branchTest(bit withStalls);
        newProgram();
        emit(iType(ADDIU, 0, 1, 16'd1));
        emit(iType(ADDIU, 0, 2, 16'd1));
        emit(iType(BEQ, 1, 2, 16'd3));      // taken, to word 6
        emit(iType(ADDIU, 0, 3, 16'd3));    // delay slot
        emit(iType(ADDIU, 0, 4, 16'd4));
        emit(iType(ADDIU, 0, 5, 16'd5));
        emit(iType(BNE, 1, 2, 16'd5));      // not taken
        emit(iType(ADDIU, 0, 6, 16'd6));
        emit(jType(26'd11));
        emit(iType(ADDIU, 0, 7, 16'd7));    // delay slot of the jump
        emit(iType(ADDIU, 0, 8, 16'd8));
        emit(iType(ADDIU, 0, 9, 16'd9));
        expectWrite(32'h00, 1, 32'd1);
        expectWrite(32'h04, 2, 32'd1);
        expectWrite(32'h0c, 3, 32'd3);
        expectWrite(32'h1c, 6, 32'd6);
        expectWrite(32'h24, 7, 32'd7);
        expectWrite(32'h2c, 9, 32'd9);
        runProgram(withStalls ? "controlStall" : "control", withStalls);
    endtask

    initial begin
        aluTest();
        forwardTest(1'b0);
        memTest(1'b0);
        branchTest(1'b0);
        forwardTest(1'b1);
        memTest(1'b1);
        branchTest(1'b1);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* filelist.f */
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/memoryUnit.sv
rtl/hazardCtrl.sv
rtl/cpuCore.sv
tests/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module cpuCoreTb -f filelist.f -o simTb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simTb > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "no result in sim.log"; exit 1; }
